/* sad_pkg.sv */
`default_nettype none

package sad_pkg;

    // geometry
    localparam int REF_SAMPLES  = 8;
    localparam int SAMPLE_BITS  = 8;
    localparam int PHASE_BITS   = 3;   // indexes one reference sample
    localparam int SAD_BITS     = 11;  // holds REF_SAMPLES * 255
    localparam int THRESH_BYTES = 2;
    localparam int BYTECNT_BITS = 3;

    // host register map
    localparam logic [7:0] ADDR_REFERENCE         = 8'h00;
    localparam logic [7:0] ADDR_THRESHOLD         = 8'h01;
    localparam logic [7:0] ADDR_STATUS            = 8'h02;
    localparam logic [7:0] ADDR_BITS_PER_SAMPLE   = 8'h03;  // read only
    localparam logic [7:0] ADDR_REF_SAMPLES       = 8'h04;  // read only
    localparam logic [7:0] ADDR_MULTIPLE_TRIGGERS = 8'h05;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [SAD_BITS-1:0]    sad_t;
    typedef logic [PHASE_BITS-1:0]  phase_t;

    // one host access, strobes are single cycle
    typedef struct packed {
        logic [7:0]              address;
        logic [BYTECNT_BITS-1:0] bytecnt;
        logic [7:0]              wdata;
        logic                    read;
        logic                    write;
    } reg_req_t;

    typedef struct packed {
        logic [8*THRESH_BYTES-1:0] threshold;  // little endian on the bus
        logic                      multiple_triggers;
    } sad_config_t;

    typedef enum logic [1:0] {
        idle,
        initializing,
        running,
        done
    } capture_state_t;

endpackage

`default_nettype wire

/* sad_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_regs (
    input  wire                                              adc_sampleclk,
    input  wire                                              reset,
    input  wire sad_pkg::reg_req_t                           req,
    output logic [7:0]                                       rdata,
    input  wire                                              triggered_event,
    output sad_pkg::sad_config_t                             cfg,
    output logic [sad_pkg::REF_SAMPLES*sad_pkg::SAMPLE_BITS-1:0] reference,
    output logic                                             clear_status
);
    import sad_pkg::*;

    logic triggered;   // sticky until the host clears it
    logic wr_status;
    logic thresh_byte_ok;

    assign wr_status      = req.write && (req.address == ADDR_STATUS);
    assign thresh_byte_ok = int'(req.bytecnt) < THRESH_BYTES;

    // reference samples, byte k holds sample k
    always_ff @(posedge adc_sampleclk) begin
        if (req.write && (req.address == ADDR_REFERENCE)) begin
            reference[req.bytecnt*SAMPLE_BITS +: SAMPLE_BITS] <= req.wdata;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            cfg          <= '0;
            triggered    <= 1'b0;
            clear_status <= 1'b0;
        end else begin
            clear_status <= wr_status;   // one cycle pulse to the FSM
            if (req.write) begin
                case (req.address)
                    ADDR_THRESHOLD: begin
                        if (thresh_byte_ok) begin
                            cfg.threshold[req.bytecnt*8 +: 8] <= req.wdata;
                        end
                    end
                    ADDR_MULTIPLE_TRIGGERS: cfg.multiple_triggers <= req.wdata[0];
                    default: ;
                endcase
            end
            // clear wins over a trigger in the same cycle
            if (wr_status) begin
                triggered <= 1'b0;
            end else if (triggered_event) begin
                triggered <= 1'b1;
            end
        end
    end

    // combinational readback
    always_comb begin
        rdata = 8'h00;
        if (req.read) begin
            case (req.address)
                ADDR_REFERENCE: rdata = reference[req.bytecnt*SAMPLE_BITS +: SAMPLE_BITS];
                ADDR_THRESHOLD: begin
                    if (thresh_byte_ok) begin
                        rdata = cfg.threshold[req.bytecnt*8 +: 8];
                    end
                end
                ADDR_STATUS:            rdata = {7'b0, triggered};
                ADDR_BITS_PER_SAMPLE:   rdata = 8'(SAMPLE_BITS);
                ADDR_REF_SAMPLES:       rdata = 8'(REF_SAMPLES);
                ADDR_MULTIPLE_TRIGGERS: rdata = {7'b0, cfg.multiple_triggers};
                default:                rdata = 8'h00;
            endcase
        end
    end

    // host never reads and writes in the same cycle
    a_no_rw_overlap: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        req.write |-> !req.read
    );

endmodule

`default_nettype wire

/* sad_diff_history.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_diff_history (
    input  wire                      adc_sampleclk,
    input  wire                      shift,
    input  wire sad_pkg::sample_t    diff_in,
    output sad_pkg::sample_t         diff_out
);
    import sad_pkg::*;

    sample_t taps [REF_SAMPLES];   // taps[0] is the newest difference

    // advances once per accumulated difference
    always_ff @(posedge adc_sampleclk) begin
        if (shift) begin
            taps[0] <= diff_in;
            for (int j = 1; j < REF_SAMPLES; j++) begin
                taps[j] <= taps[j-1];
            end
        end
    end

    // difference from REF_SAMPLES shifts back
    assign diff_out = taps[REF_SAMPLES-1];

endmodule

`default_nettype wire

/* sad_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_lane (
    input  wire                                              adc_sampleclk,
    input  wire                                              lane_active,
    input  wire sad_pkg::sample_t                            sample,
    input  wire [sad_pkg::REF_SAMPLES*sad_pkg::SAMPLE_BITS-1:0] reference,
    input  wire sad_pkg::sad_config_t                        cfg,
    output logic                                             lane_match
);
    import sad_pkg::*;

    localparam phase_t LAST_PHASE = phase_t'(REF_SAMPLES - 1);

    phase_t  phase;        // which reference sample the current input meets
    phase_t  diff_phase;
    phase_t  sum_phase;    // phase of the newest difference in sum
    sample_t ref_sample;
    sample_t abs_diff;
    sample_t diff;
    sample_t hist_out;
    logic    diff_valid;
    logic    filled;       // sum spans a full window
    logic    accumulate;
    sad_t    sum;

    assign ref_sample = reference[phase*SAMPLE_BITS +: SAMPLE_BITS];
    assign abs_diff   = (sample > ref_sample) ? sample - ref_sample : ref_sample - sample;
    assign accumulate = lane_active && diff_valid;

    always_ff @(posedge adc_sampleclk) begin
        if (!lane_active || (phase == LAST_PHASE)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // difference stage
    always_ff @(posedge adc_sampleclk) begin
        diff       <= abs_diff;
        diff_phase <= phase;
        diff_valid <= lane_active;
    end

    sad_diff_history u_history (
        .adc_sampleclk (adc_sampleclk),
        .shift         (accumulate),
        .diff_in       (diff),
        .diff_out      (hist_out)
    );

    // running sum, old difference drops out once the window is full
    always_ff @(posedge adc_sampleclk) begin
        if (!lane_active) begin
            sum    <= '0;
            filled <= 1'b0;
        end else if (accumulate) begin
            if (filled) begin
                sum <= sum + sad_t'(diff) - sad_t'(hist_out);
            end else begin
                sum <= sum + sad_t'(diff);
            end
            sum_phase <= diff_phase;
            if (diff_phase == LAST_PHASE) begin
                filled <= 1'b1;   // first wrap
            end
        end
    end

    // match only when the window lines up with reference sample 0
    always_ff @(posedge adc_sampleclk) begin
        lane_match <= lane_active && filled && (sum_phase == LAST_PHASE)
                      && (16'(sum) <= cfg.threshold);
    end

    // a window holds at most REF_SAMPLES full scale differences
    a_sum_range: assert property (
        @(posedge adc_sampleclk)
        lane_active |-> int'(sum) <= REF_SAMPLES * ((1 << SAMPLE_BITS) - 1)
    );

endmodule

`default_nettype wire

/* sad_control.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_control (
    input  wire                              adc_sampleclk,
    input  wire                              reset,
    input  wire                              armed_and_ready,
    input  wire                              active,
    input  wire                              clear_status,
    input  wire sad_pkg::sad_config_t        cfg,
    input  wire [sad_pkg::REF_SAMPLES-1:0]   lane_match,
    output logic [sad_pkg::REF_SAMPLES-1:0]  lane_active,
    output logic                             trigger
);
    import sad_pkg::*;

    capture_state_t state;
    phase_t         start_cnt;   // next lane to start
    logic           any_match;

    assign any_match = |lane_match;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state       <= idle;
            start_cnt   <= '0;
            lane_active <= '0;
            trigger     <= 1'b0;
        end else begin
            trigger <= 1'b0;
            case (state)
                idle: begin
                    start_cnt   <= '0;
                    lane_active <= '0;
                    if (armed_and_ready && active) begin
                        state <= initializing;
                    end
                end

                // one lane per cycle, so lane i sees reference phase 0 on sample i
                initializing: begin
                    if (!active) begin
                        state <= done;
                    end else begin
                        lane_active[start_cnt] <= 1'b1;
                        start_cnt              <= start_cnt + 1'b1;
                        if (start_cnt == phase_t'(REF_SAMPLES - 1)) begin
                            state <= running;
                        end
                    end
                end

                running: begin
                    if (!active) begin
                        state <= done;          // in-flight matches are dropped
                    end else if (any_match) begin
                        trigger <= 1'b1;
                        if (!cfg.multiple_triggers) begin
                            state <= done;
                        end
                    end
                end

                done: begin
                    lane_active <= '0;
                    if (!armed_and_ready || clear_status) begin
                        state <= idle;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // a trigger only comes out of a capture with every lane started
    a_trigger_all_lanes: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        trigger |-> &lane_active
    );

endmodule

`default_nettype wire

/* sad_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_trigger (
    input  wire                      adc_sampleclk,
    input  wire                      reset,
    input  wire sad_pkg::sample_t    adc_datain,
    input  wire                      armed_and_ready,
    input  wire                      active,
    input  wire sad_pkg::reg_req_t   reg_req,
    output logic [7:0]               reg_rdata,
    output logic                     trigger
);
    import sad_pkg::*;

    sample_t                          adc_datain_r;
    sad_config_t                      cfg;
    logic [REF_SAMPLES*SAMPLE_BITS-1:0] reference;
    logic                             clear_status;
    logic [REF_SAMPLES-1:0]           lane_active;
    logic [REF_SAMPLES-1:0]           lane_match;

    // single input register, shared by all lanes
    always_ff @(posedge adc_sampleclk) begin
        adc_datain_r <= adc_datain;
    end

    sad_regs u_regs (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .req             (reg_req),
        .rdata           (reg_rdata),
        .triggered_event (trigger),
        .cfg             (cfg),
        .reference       (reference),
        .clear_status    (clear_status)
    );

    sad_control u_control (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .clear_status    (clear_status),
        .cfg             (cfg),
        .lane_match      (lane_match),
        .lane_active     (lane_active),
        .trigger         (trigger)
    );

    for (genvar i = 0; i < REF_SAMPLES; i++) begin : gen_lane
        sad_lane u_lane (
            .adc_sampleclk (adc_sampleclk),
            .lane_active   (lane_active[i]),
            .sample        (adc_datain_r),
            .reference     (reference),
            .cfg           (cfg),
            .lane_match    (lane_match[i])
        );
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic adc_sampleclk,
    output logic reset
);

    initial begin
        adc_sampleclk = 1'b0;
        forever #(PERIOD_NS / 2) adc_sampleclk = ~adc_sampleclk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge adc_sampleclk);
        @(negedge adc_sampleclk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_sad_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sad_trigger;
    import sad_pkg::*;

    localparam int          CLK_PERIOD_NS   = 4;
    localparam int          RESET_CYCLES    = 8;
    localparam logic [31:0] SEED            = 32'd72748;
    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 200;
    localparam int          WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS;
    localparam int          EXPECT_DEPTH    = 2048;
    localparam int          STREAM_MAX      = 64;
    localparam int          PIPE_EDGES      = 4;   // s_k in the input register to trigger
    localparam int          DRAIN_CYCLES    = 12;
    localparam int          READ_SETTLE_NS  = 1;

    logic        adc_sampleclk;
    logic        reset;
    sample_t     adc_datain;
    logic        armed_and_ready;
    logic        active;
    reg_req_t    reg_req;
    logic [7:0]  reg_rdata;
    logic        trigger;

    logic [31:0] rng_state;
    sample_t     stream [STREAM_MAX];
    sample_t     ref_model [REF_SAMPLES];
    logic [15:0] threshold_model;
    logic        multi_model;
    logic        expect_trig [EXPECT_DEPTH];   // indexed by rising edge number
    int          cyc_count = 0;
    int          trig_pulses = 0;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset)
    );

    sad_trigger UUT (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_req         (reg_req),
        .reg_rdata       (reg_rdata),
        .trigger         (trigger)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sample_t next_random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    function automatic void fill_random_stream(input int n);
        for (int j = 0; j < n; j++) begin
            stream[j] = next_random_byte();
        end
    endfunction

    // copy of the reference ending at sample last, offset makes a near copy
    function automatic void embed_copy(input int last, input int offset);
        int v;
        for (int j = 0; j < REF_SAMPLES; j++) begin
            v = int'(ref_model[j]);
            v = (v < 128) ? v + offset : v - offset;   // stays inside 0..255
            stream[last - REF_SAMPLES + 1 + j] = sample_t'(v);
        end
    endfunction

    // sad of window W_last against reference samples 0..REF_SAMPLES-1
    function automatic int sad_of_window(input int last);
        int total;
        int a;
        int b;
        total = 0;
        for (int j = 0; j < REF_SAMPLES; j++) begin
            a = int'(stream[last - REF_SAMPLES + 1 + j]);
            b = int'(ref_model[j]);
            total += (a > b) ? a - b : b - a;
        end
        return total;
    endfunction

    // W_k fires on edge E0 + k + 1 + PIPE_EDGES, only while active was still high
    function automatic int predict_triggers(input int start_edge, input int stop_at);
        int fired;
        fired = 0;
        for (int k = REF_SAMPLES - 1; k + 1 + PIPE_EDGES <= stop_at; k++) begin
            if ((fired == 0 || multi_model) && sad_of_window(k) <= int'(threshold_model)) begin
                expect_trig[start_edge + k + 1 + PIPE_EDGES] = 1'b1;
                fired++;
            end
        end
        return fired;
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [BYTECNT_BITS-1:0] idx,
                             input logic [7:0] data);
        @(negedge adc_sampleclk);
        reg_req         = '0;
        reg_req.address = addr;
        reg_req.bytecnt = idx;
        reg_req.wdata   = data;
        reg_req.write   = 1'b1;
        @(negedge adc_sampleclk);
        reg_req = '0;
    endtask

    task automatic check_reg(input string name, input logic [7:0] addr,
                             input logic [BYTECNT_BITS-1:0] idx, input logic [7:0] expected);
        @(negedge adc_sampleclk);
        reg_req         = '0;
        reg_req.address = addr;
        reg_req.bytecnt = idx;
        reg_req.read    = 1'b1;
        #(READ_SETTLE_NS);
        check_equal(name, 32'(reg_rdata), 32'(expected));
        @(negedge adc_sampleclk);
        reg_req = '0;
    endtask

    task automatic load_reference();
        for (int i = 0; i < REF_SAMPLES; i++) begin
            write_reg(ADDR_REFERENCE, BYTECNT_BITS'(i), ref_model[i]);
        end
    endtask

    task automatic set_threshold(input logic [15:0] thr);
        threshold_model = thr;
        write_reg(ADDR_THRESHOLD, 3'd0, thr[7:0]);   // little endian
        write_reg(ADDR_THRESHOLD, 3'd1, thr[15:8]);
    endtask

    task automatic set_mode(input logic multi);
        multi_model = multi;
        write_reg(ADDR_MULTIPLE_TRIGGERS, 3'd0, {7'b0, multi});
    endtask

    // stream n samples, active drops on the cycle that would carry s_stop_at
    task automatic run_capture(input int n, input int stop_at,
                               output int predicted, output int observed);
        int start_edge;
        int pulses_before;
        @(negedge adc_sampleclk);
        armed_and_ready = 1'b1;
        active          = 1'b1;
        start_edge      = cyc_count + 1;   // idle to initializing
        pulses_before   = trig_pulses;
        predicted       = predict_triggers(start_edge, (stop_at < n) ? stop_at : n);
        for (int j = 0; j < n; j++) begin
            @(negedge adc_sampleclk);
            adc_datain = stream[j];
            if (j == stop_at) begin
                active = 1'b0;
            end
        end
        @(negedge adc_sampleclk);
        active          = 1'b0;
        armed_and_ready = 1'b0;   // back to idle from done
        repeat (DRAIN_CYCLES) @(negedge adc_sampleclk);
        observed = trig_pulses - pulses_before;
    endtask

    always @(posedge adc_sampleclk) begin
        cyc_count <= cyc_count + 1;
    end

    // trigger is registered, so mid-cycle is a stable point
    always @(negedge adc_sampleclk) begin
        if (!reset) begin
            check_equal("trigger", 32'(trigger), 32'(expect_trig[cyc_count]));
            if (trigger) begin
                trig_pulses = trig_pulses + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before the tests finished");
    end

    initial begin
        int          predicted;
        int          observed;
        logic [15:0] thr;
        adc_datain      = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_req         = '0;
        rng_state       = SEED;
        threshold_model = '0;
        multi_model     = 1'b0;
        for (int i = 0; i < EXPECT_DEPTH; i++) begin
            expect_trig[i] = 1'b0;
        end
        wait (reset === 1'b0);
        @(negedge adc_sampleclk);

        $display("register readback");
        for (int i = 0; i < REF_SAMPLES; i++) begin
            ref_model[i] = next_random_byte();
        end
        load_reference();
        thr = {next_random_byte(), next_random_byte()};
        set_threshold(thr);
        for (int i = 0; i < REF_SAMPLES; i++) begin
            check_reg("reg_rdata reference", ADDR_REFERENCE, BYTECNT_BITS'(i), ref_model[i]);
        end
        check_reg("reg_rdata threshold low", ADDR_THRESHOLD, 3'd0, thr[7:0]);
        check_reg("reg_rdata threshold high", ADDR_THRESHOLD, 3'd1, thr[15:8]);
        check_reg("reg_rdata bits per sample", ADDR_BITS_PER_SAMPLE, 3'd0, 8'd8);
        check_reg("reg_rdata ref samples", ADDR_REF_SAMPLES, 3'd0, 8'd8);
        @(negedge adc_sampleclk);
        reg_req         = '0;
        reg_req.address = ADDR_REF_SAMPLES;   // strobe low
        #(READ_SETTLE_NS);
        check_equal("reg_rdata without read", 32'(reg_rdata), 32'h0);

        $display("single trigger");
        set_mode(1'b0);
        set_threshold(16'd0);
        fill_random_stream(48);
        embed_copy(30, 0);
        embed_copy(40, 0);   // a second match after the capture is done
        run_capture(48, 48, predicted, observed);
        check_equal("expected window count", 32'(predicted), 32'd1);
        check_equal("trigger pulses", 32'(observed), 32'd1);

        $display("status and rearm");
        check_reg("reg_rdata status", ADDR_STATUS, 3'd0, 8'h01);
        write_reg(ADDR_STATUS, 3'd0, 8'h00);
        check_reg("reg_rdata status", ADDR_STATUS, 3'd0, 8'h00);
        fill_random_stream(40);
        embed_copy(20, 0);
        run_capture(40, 40, predicted, observed);
        check_equal("trigger pulses", 32'(observed), 32'd1);
        check_reg("reg_rdata status", ADDR_STATUS, 3'd0, 8'h01);

        $display("multiple triggers");
        set_mode(1'b1);
        check_reg("reg_rdata multiple triggers", ADDR_MULTIPLE_TRIGGERS, 3'd0, 8'h01);
        set_threshold(16'd700);   // roughly half of random windows
        fill_random_stream(STREAM_MAX);
        run_capture(STREAM_MAX, STREAM_MAX, predicted, observed);
        if (predicted == 0) begin
            stop_with_failure("random stream gave no matching window for the multiple test");
        end
        check_equal("trigger pulses", 32'(observed), 32'(predicted));

        $display("no false match");
        write_reg(ADDR_STATUS, 3'd0, 8'h00);
        fill_random_stream(48);
        embed_copy(30, 3);
        set_threshold(16'(sad_of_window(30) - 1));
        run_capture(48, 48, predicted, observed);
        check_equal("trigger pulses", 32'(observed), 32'd0);
        check_reg("reg_rdata status", ADDR_STATUS, 3'd0, 8'h00);

        $display("stop on inactive");
        set_threshold(16'd0);
        fill_random_stream(48);
        embed_copy(18, 0);   // completes before active falls
        embed_copy(27, 0);   // still in the pipeline
        embed_copy(36, 0);   // ends after active falls
        run_capture(48, 30, predicted, observed);
        check_equal("trigger pulses", 32'(observed), 32'd1);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
sad_pkg.sv
sad_regs.sv
sad_diff_history.sv
sad_lane.sv
sad_control.sv
sad_trigger.sv
tb_clock.sv
tb_sad_trigger.sv

/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: obj_dir/Vtb_sad_trigger

# rebuilt only when the file list or a source changes
obj_dir/Vtb_sad_trigger: src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_sad_trigger -f src.f

# exit status of the simulator is the test result
run: obj_dir/Vtb_sad_trigger
	./obj_dir/Vtb_sad_trigger

clean:
	rm -rf obj_dir
